// File: Bender.yml
package:
  name: pkt_decode

sources:
  - files:
      - logic/cmd_pkg.sv
      - logic/cmd_parser.sv
      - logic/io_ctrl_exec.sv
      - logic/resp_framer.sv
      - logic/pkt_decode_top.sv
  - target: test
    files:
      - sim/pkt_decode_props.sv
      - sim/pkt_decode_tb.sv

// File: logic/cmd_parser.sv
// Command parser FSM, turns the ASCII word stream into one decoded message per packet
`timescale 1ns/1ps

module cmd_parser (
   input  logic                clk,
   input  logic                i_arst_n,
   input  cmd_pkg::rx_beat_t   i_rx,
   output cmd_pkg::cmd_msg_t   o_msg,
   output logic                o_msg_vd
);

   typedef enum logic [2:0] {
      st_idle,
      st_head,
      st_type,
      st_mode,
      st_chan,
      st_data,
      st_end
   } parse_st_t;

   parse_st_t          state;
   cmd_pkg::cmd_msg_t  msg_q;
   cmd_pkg::hex_nib_t  nib_hi;
   cmd_pkg::hex_nib_t  nib_lo;
   logic [7:0]         rx_byte;
   logic               rx_hex_err;
   logic               rx_is_end;
   logic               eop_counts;

   //////////////////////////////////////////////////////////////////////
   // Per-word decode
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      nib_hi     = cmd_pkg::hex_to_nibble(i_rx.word[15:8]);
      nib_lo     = cmd_pkg::hex_to_nibble(i_rx.word[7:0]);
      rx_byte    = {nib_hi.nib, nib_lo.nib};
      rx_hex_err = nib_hi.err | nib_lo.err;
   end

   // End word is recognised by its first character alone
   assign rx_is_end = (i_rx.word[15:8] == cmd_pkg::char_cr) ||
                      (i_rx.word[15:8] == cmd_pkg::char_lf);

   // eop closes a message once the type is known
   assign eop_counts = (state == st_mode) || (state == st_chan) ||
                       (state == st_data) || (state == st_end);

   //////////////////////////////////////////////////////////////////////
   // Field walk
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state    <= st_idle;
         msg_q    <= '0;
         o_msg_vd <= 1'b0;
      end else begin
         o_msg_vd <= 1'b0;
         if (i_rx.sop) begin
            // New packet, fields start from zero
            msg_q <= '0;
            if (i_rx.valid && i_rx.word == cmd_pkg::msg_head)
               state <= st_type;
            else
               state <= st_head;
         end else begin
            case (state)
               st_head: begin
                  if (i_rx.valid && i_rx.word == cmd_pkg::msg_head)
                     state <= st_type;
               end
               st_type: begin
                  if (i_rx.valid) begin
                     msg_q.type_w <= i_rx.word;
                     state        <= st_mode;
                  end
               end
               st_mode: begin
                  if (i_rx.valid) begin
                     if (rx_is_end) begin
                        state <= st_end;
                     end else begin
                        msg_q.mode_w <= i_rx.word;
                        state        <= st_chan;
                     end
                  end
               end
               st_chan: begin
                  if (i_rx.valid) begin
                     if (rx_is_end) begin
                        state <= st_end;
                     end else begin
                        msg_q.chan_w  <= i_rx.word;
                        msg_q.bank    <= rx_byte;
                        msg_q.hex_err <= msg_q.hex_err | rx_hex_err;
                        state         <= st_data;
                     end
                  end
               end
               st_data: begin
                  if (i_rx.valid) begin
                     if (rx_is_end) begin
                        state <= st_end;
                     end else begin
                        // Oldest byte ends up in the mask field
                        msg_q.payload <= {msg_q.payload[2*cmd_pkg::io_nbit-1:0], rx_byte};
                        msg_q.hex_err <= msg_q.hex_err | rx_hex_err;
                        if (msg_q.cnt != '1)
                           msg_q.cnt <= msg_q.cnt + 1'b1;
                     end
                  end
               end
               default: ;
            endcase
            if (i_rx.eop) begin
               o_msg_vd <= eop_counts;
               state    <= st_idle;
            end
         end
      end
   end

   assign o_msg = msg_q;

endmodule

// File: logic/cmd_pkg.sv
// Command packet widths, protocol words, beat and message structs, hex conversion
package cmd_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////
   localparam int word_nbit   = 16;
   localparam int io_nbit     = 8;
   localparam int io_data_num = 3;
   localparam int cnt_nbit    = 4;

   //////////////////////////////////////////////////////////////////////
   // Protocol words, two ASCII characters each, first one in the upper byte
   //////////////////////////////////////////////////////////////////////
   localparam logic [7:0] char_cr = 8'h0d;
   localparam logic [7:0] char_lf = 8'h0a;

   localparam logic [word_nbit-1:0] msg_head       = "ST";
   localparam logic [word_nbit-1:0] type_handshake = "00";
   localparam logic [word_nbit-1:0] type_io        = "02";

   localparam logic [word_nbit-1:0] mode_set = "01";
   localparam logic [word_nbit-1:0] mode_exe = "02";
   localparam logic [word_nbit-1:0] mode_sex = "03";
   localparam logic [word_nbit-1:0] mode_rtn = "04";

   localparam logic [word_nbit-1:0] word_pass = "OK";
   localparam logic [word_nbit-1:0] word_fail = "ER";

   // Result codes, 0x for set, 1x for execute, 2x for set and execute
   localparam logic [word_nbit-1:0] code_00 = "00";
   localparam logic [word_nbit-1:0] code_01 = "01";
   localparam logic [word_nbit-1:0] code_02 = "02";
   localparam logic [word_nbit-1:0] code_03 = "03";
   localparam logic [word_nbit-1:0] code_11 = "11";
   localparam logic [word_nbit-1:0] code_12 = "12";
   localparam logic [word_nbit-1:0] code_21 = "21";
   localparam logic [word_nbit-1:0] code_22 = "22";
   localparam logic [word_nbit-1:0] code_23 = "23";

   localparam logic [word_nbit-1:0] word_end = {char_cr, char_lf};

   //////////////////////////////////////////////////////////////////////
   // Stream beats and messages
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic                 valid;
      logic                 sop;
      logic                 eop;
      logic [word_nbit-1:0] word;
   } rx_beat_t;

   typedef struct packed {
      logic                 valid;
      logic                 eop;
      logic [word_nbit-1:0] word;
   } tx_beat_t;

   // IO bank state, dir 1 means output, mask 1 keeps the old bit
   typedef struct packed {
      logic [io_nbit-1:0] mask;
      logic [io_nbit-1:0] dir;
      logic [io_nbit-1:0] data;
   } io_state_t;

   typedef struct packed {
      logic [word_nbit-1:0] type_w;
      logic [word_nbit-1:0] mode_w;
      logic [word_nbit-1:0] chan_w;
      logic [io_nbit-1:0]   bank;
      io_state_t            payload;
      logic [cnt_nbit-1:0]  cnt;
      logic                 hex_err;
   } cmd_msg_t;

   typedef struct packed {
      logic [word_nbit-1:0] type_w;
      logic [word_nbit-1:0] pf_w;
      logic [word_nbit-1:0] code_w;
      logic [word_nbit-1:0] chan_w;
      io_state_t            state;
      logic                 has_body;
   } resp_t;

   typedef struct packed {
      logic       err;
      logic [3:0] nib;
   } hex_nib_t;

   //////////////////////////////////////////////////////////////////////
   // Hex character conversion
   //////////////////////////////////////////////////////////////////////
   function automatic hex_nib_t hex_to_nibble(input logic [7:0] i_char);
      hex_nib_t   res;
      logic [7:0] val;
      res.err = 1'b0;
      val     = 8'h00;
      if (i_char >= "0" && i_char <= "9")
         val = i_char - "0";
      else if (i_char >= "a" && i_char <= "f")
         val = i_char - ("a" - 8'd10);
      else if (i_char >= "A" && i_char <= "F")
         val = i_char - ("A" - 8'd10);
      else
         res.err = 1'b1;
      res.nib = val[3:0];
      return res;
   endfunction

   // Uppercase letters only on the way out
   function automatic logic [7:0] nibble_to_hex(input logic [3:0] i_nib);
      if (i_nib < 4'd10)
         return 8'h30 + {4'h0, i_nib};
      return 8'h37 + {4'h0, i_nib};
   endfunction

endpackage

// File: logic/io_ctrl_exec.sv
// IO control executor, mode and length checks, IO state update, port drive, response info
`timescale 1ns/1ps

module io_ctrl_exec (
   input  logic                          clk,
   input  logic                          i_arst_n,
   input  cmd_pkg::cmd_msg_t             i_msg,
   input  logic                          i_msg_vd,
   input  logic [cmd_pkg::io_nbit-1:0]   i_io_db,
   output logic [cmd_pkg::io_nbit-1:0]   o_io_dir,
   output logic [cmd_pkg::io_nbit-1:0]   o_io_db,
   output logic [cmd_pkg::io_nbit-1:0]   o_io_bank,
   output cmd_pkg::resp_t                o_resp,
   output logic                          o_resp_start
);

   logic                              dec_go;
   logic                              dec_set;
   logic                              dec_exe;
   logic                              dec_body;
   logic [cmd_pkg::word_nbit-1:0]     dec_pf;
   logic [cmd_pkg::word_nbit-1:0]     dec_code;
   logic                              go_q;
   logic                              set_q;
   logic                              exe_q;
   logic                              body_q;
   logic [cmd_pkg::word_nbit-1:0]     pf_q;
   logic [cmd_pkg::word_nbit-1:0]     code_q;
   logic [cmd_pkg::word_nbit-1:0]     type_q;
   logic [cmd_pkg::word_nbit-1:0]     chan_q;
   logic [cmd_pkg::io_nbit-1:0]       bank_q;
   cmd_pkg::io_state_t                pay_q;
   cmd_pkg::io_state_t                st_q;
   cmd_pkg::io_state_t                st_new;
   logic                              cnt_full;
   logic                              cnt_zero;

   assign cnt_full = (i_msg.cnt == cmd_pkg::cnt_nbit'(cmd_pkg::io_data_num));
   assign cnt_zero = (i_msg.cnt == '0);

   //////////////////////////////////////////////////////////////////////
   // Result table
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      dec_go   = 1'b0;
      dec_set  = 1'b0;
      dec_exe  = 1'b0;
      dec_body = 1'b0;
      dec_pf   = cmd_pkg::word_fail;
      dec_code = cmd_pkg::code_00;
      case (i_msg.type_w)
         cmd_pkg::type_handshake: begin
            dec_go   = 1'b1;
            dec_pf   = cmd_pkg::word_pass;
            dec_code = cmd_pkg::code_01;
         end
         cmd_pkg::type_io: begin
            dec_go   = 1'b1;
            dec_body = 1'b1;
            case (i_msg.mode_w)
               cmd_pkg::mode_set: begin
                  if (!cnt_full) begin
                     dec_code = cmd_pkg::code_02;
                  end else if (i_msg.hex_err) begin
                     dec_code = cmd_pkg::code_03;
                  end else begin
                     dec_pf   = cmd_pkg::word_pass;
                     dec_code = cmd_pkg::code_01;
                     dec_set  = 1'b1;
                  end
               end
               cmd_pkg::mode_exe: begin
                  if (cnt_zero) begin
                     dec_pf   = cmd_pkg::word_pass;
                     dec_code = cmd_pkg::code_11;
                     dec_exe  = 1'b1;
                  end else begin
                     dec_code = cmd_pkg::code_12;
                  end
               end
               cmd_pkg::mode_sex: begin
                  if (!cnt_full) begin
                     dec_code = cmd_pkg::code_22;
                  end else if (i_msg.hex_err) begin
                     dec_code = cmd_pkg::code_23;
                  end else begin
                     dec_pf   = cmd_pkg::word_pass;
                     dec_code = cmd_pkg::code_21;
                     dec_set  = 1'b1;
                     dec_exe  = 1'b1;
                  end
               end
               cmd_pkg::mode_rtn: begin
                  dec_pf   = i_msg.hex_err ? cmd_pkg::word_fail : cmd_pkg::word_pass;
                  dec_code = i_msg.hex_err ? cmd_pkg::code_23 : cmd_pkg::code_21;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

   // Decision and payload held until the next message
   always_ff @(posedge clk) begin
      if (i_msg_vd) begin
         set_q  <= dec_set;
         exe_q  <= dec_exe;
         body_q <= dec_body;
         pf_q   <= dec_pf;
         code_q <= dec_code;
         type_q <= i_msg.type_w;
         chan_q <= i_msg.chan_w;
         bank_q <= i_msg.bank;
         pay_q  <= i_msg.payload;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // State merge and port drive
   //////////////////////////////////////////////////////////////////////
   // Masked bits hold, unmasked inputs sample the pins
   assign st_new.mask = pay_q.mask;
   assign st_new.dir  = (pay_q.mask & st_q.dir) | (~pay_q.mask & pay_q.dir);
   assign st_new.data = (pay_q.mask & st_q.data) |
                        (~pay_q.mask & ((st_new.dir & pay_q.data) | (~st_new.dir & i_io_db)));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         go_q         <= 1'b0;
         o_resp_start <= 1'b0;
         st_q         <= '0;
         o_io_dir     <= '0;
         o_io_db      <= '0;
         o_io_bank    <= '0;
      end else begin
         go_q         <= i_msg_vd & dec_go;
         o_resp_start <= go_q;
         if (go_q && set_q)
            st_q <= st_new;
         if (go_q && exe_q) begin
            o_io_dir  <= set_q ? st_new.dir : st_q.dir;
            o_io_db   <= set_q ? st_new.data : st_q.data;
            o_io_bank <= bank_q;
         end
      end
   end

   // State field reads the stored value, already updated when start is seen
   assign o_resp = '{type_w: type_q, pf_w: pf_q, code_w: code_q, chan_w: chan_q,
                     state: st_q, has_body: body_q};

endmodule

// File: logic/pkt_decode_top.sv
// Packet decoder top, parser to IO executor to response framer
`timescale 1ns/1ps

module pkt_decode_top (
   input  logic                          clk,
   input  logic                          i_arst_n,
   input  cmd_pkg::rx_beat_t             i_rx,
   output cmd_pkg::tx_beat_t             o_tx,
   input  logic [cmd_pkg::io_nbit-1:0]   i_io_db,
   output logic [cmd_pkg::io_nbit-1:0]   o_io_dir,
   output logic [cmd_pkg::io_nbit-1:0]   o_io_db,
   output logic [cmd_pkg::io_nbit-1:0]   o_io_bank
);

   cmd_pkg::cmd_msg_t  msg;
   logic               msg_vd;
   cmd_pkg::resp_t     resp;
   logic               resp_start;

   cmd_parser u_cmd_parser (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_rx     (i_rx),
      .o_msg    (msg),
      .o_msg_vd (msg_vd)
   );

   io_ctrl_exec u_io_ctrl_exec (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_msg        (msg),
      .i_msg_vd     (msg_vd),
      .i_io_db      (i_io_db),
      .o_io_dir     (o_io_dir),
      .o_io_db      (o_io_db),
      .o_io_bank    (o_io_bank),
      .o_resp       (resp),
      .o_resp_start (resp_start)
   );

   resp_framer u_resp_framer (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_resp       (resp),
      .i_resp_start (resp_start),
      .o_tx         (o_tx)
   );

endmodule

// File: logic/resp_framer.sv
// Response framer, serializes the response descriptor into ASCII words
`timescale 1ns/1ps

module resp_framer (
   input  logic              clk,
   input  logic              i_arst_n,
   input  cmd_pkg::resp_t    i_resp,
   input  logic              i_resp_start,
   output cmd_pkg::tx_beat_t o_tx
);

   // Word order on the wire, the body words exist for IO responses only
   typedef enum logic [3:0] {
      wd_head,
      wd_type,
      wd_pf,
      wd_code,
      wd_chan,
      wd_mask,
      wd_dir,
      wd_data,
      wd_end
   } word_sel_t;

   cmd_pkg::resp_t                 resp_q;
   word_sel_t                      sel;
   logic                           busy;
   logic                           take;
   logic                           last;
   logic [cmd_pkg::io_nbit-1:0]    hex_byte;
   logic [cmd_pkg::word_nbit-1:0]  next_word;
   logic                           tx_vd;
   logic                           tx_eop;
   logic [cmd_pkg::word_nbit-1:0]  tx_word;

   // Start while busy is lost
   assign take = i_resp_start & ~busy;
   assign last = (sel == wd_end) || (sel == wd_code && !resp_q.has_body);

   //////////////////////////////////////////////////////////////////////
   // Word select
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      case (sel)
         wd_dir:  hex_byte = resp_q.state.dir;
         wd_data: hex_byte = resp_q.state.data;
         default: hex_byte = resp_q.state.mask;
      endcase
      case (sel)
         wd_head: next_word = cmd_pkg::msg_head;
         wd_type: next_word = resp_q.type_w;
         wd_pf:   next_word = resp_q.pf_w;
         wd_code: next_word = resp_q.code_w;
         wd_chan: next_word = resp_q.chan_w;
         wd_mask, wd_dir, wd_data: begin
            next_word = {cmd_pkg::nibble_to_hex(hex_byte[7:4]),
                         cmd_pkg::nibble_to_hex(hex_byte[3:0])};
         end
         default: next_word = cmd_pkg::word_end;
      endcase
   end

   // Descriptor latch and word register
   always_ff @(posedge clk) begin
      if (take) begin
         resp_q  <= i_resp;
         tx_word <= cmd_pkg::msg_head;
      end else if (busy) begin
         tx_word <= next_word;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Sequencer
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         busy   <= 1'b0;
         sel    <= wd_head;
         tx_vd  <= 1'b0;
         tx_eop <= 1'b0;
      end else begin
         tx_vd  <= take | busy;
         tx_eop <= busy & last;
         if (take) begin
            // Head leaves together with the latch
            busy <= 1'b1;
            sel  <= wd_type;
         end else if (busy) begin
            if (last) begin
               busy <= 1'b0;
               sel  <= wd_head;
            end else begin
               sel  <= word_sel_t'(sel + 1'b1);
            end
         end
      end
   end

   assign o_tx = '{valid: tx_vd, eop: tx_eop, word: tx_word};

endmodule

// File: sim.f
logic/cmd_pkg.sv
logic/cmd_parser.sv
logic/io_ctrl_exec.sv
logic/resp_framer.sv
logic/pkt_decode_top.sv
sim/pkt_decode_props.sv
sim/pkt_decode_tb.sv

// File: sim/pkt_decode_props.sv
// Bound port properties of the packet decoder top, eop framing, reset values, head word first
`timescale 1ns/1ps

module pkt_decode_props (
   input logic                          clk,
   input logic                          i_arst_n,
   input cmd_pkg::tx_beat_t             i_tx,
   input logic [cmd_pkg::io_nbit-1:0]   i_io_dir,
   input logic [cmd_pkg::io_nbit-1:0]   i_io_db,
   input logic [cmd_pkg::io_nbit-1:0]   i_io_bank
);

   int unsigned prop_errs = 0;

   // Last word marker only on a real word
   eop_has_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_tx.eop |-> i_tx.valid) else begin
      prop_errs++;
      $error("eop was high without valid");
   end

   reset_quiet: assert property (@(posedge clk)
      !i_arst_n |-> !i_tx.valid && !i_tx.eop && i_io_dir == '0 &&
                    i_io_db == '0 && i_io_bank == '0) else begin
      prop_errs++;
      $error("outputs were active while reset was held");
   end

   // A response always opens with the head word
   head_first: assert property (@(posedge clk) disable iff (!i_arst_n)
      $rose(i_tx.valid) |-> i_tx.word == cmd_pkg::msg_head) else begin
      prop_errs++;
      $error("first word after an idle gap was not the head word");
   end

endmodule

bind pkt_decode_top pkt_decode_props u_props (
   .clk       (clk),
   .i_arst_n  (i_arst_n),
   .i_tx      (o_tx),
   .i_io_dir  (o_io_dir),
   .i_io_db   (o_io_db),
   .i_io_bank (o_io_bank)
);

// File: sim/pkt_decode_tb.sv
// Packet decoder testbench with clock, reset, command table, reference model and response checks
`timescale 1ns/1ps

module pkt_decode_tb;

   localparam int resp_timeout = 20;

   // One command per row; data words beyond n_data are not sent
   typedef struct packed {
      logic [15:0]      type_w;
      logic [15:0]      mode_w;
      logic [15:0]      chan_w;
      logic [1:0]       n_data;
      logic [0:2][15:0] data;
      logic [7:0]       io_db;
      logic             rnd_db;
   } pkt_row_t;

   logic                clk;
   logic                i_arst_n;
   cmd_pkg::rx_beat_t   i_rx;
   cmd_pkg::tx_beat_t   o_tx;
   logic [7:0]          i_io_db;
   logic [7:0]          o_io_dir;
   logic [7:0]          o_io_db;
   logic [7:0]          o_io_bank;
   pkt_row_t            rows[$];
   logic [15:0]         exp_words[$];
   cmd_pkg::io_state_t  exp_st;
   logic [7:0]          exp_dir;
   logic [7:0]          exp_dbo;
   logic [7:0]          exp_bank;
   int                  n_checks;
   int                  n_errs;

   pkt_decode_top i_pkt_decode_top (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_rx      (i_rx),
      .o_tx      (o_tx),
      .i_io_db   (i_io_db),
      .o_io_dir  (o_io_dir),
      .o_io_db   (o_io_db),
      .o_io_bank (o_io_bank)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ///////////////////////////////////////////////////////////////////////
   // Helpers
   ///////////////////////////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         n_errs++;
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   function automatic logic word_ok(input logic [15:0] w);
      return (w[15:8] inside {[8'h30:8'h39], [8'h41:8'h46], [8'h61:8'h66]}) &&
             (w[7:0] inside {[8'h30:8'h39], [8'h41:8'h46], [8'h61:8'h66]});
   endfunction

   function automatic logic [3:0] char_val(input logic [7:0] c);
      logic [7:0] v;
      if (c <= 8'h39)
         v = c - 8'h30;
      else
         v = (c | 8'h20) - 8'h57;
      return v[3:0];
   endfunction

   function automatic logic [7:0] word_byte(input logic [15:0] w);
      return {char_val(w[15:8]), char_val(w[7:0])};
   endfunction

   // Uppercase digit lookup
   function automatic logic [15:0] byte_ascii(input logic [7:0] b);
      string digits;
      digits = "0123456789ABCDEF";
      return {digits[b[7:4]], digits[b[3:0]]};
   endfunction

   task automatic add_row(input logic [15:0] type_w, input logic [15:0] mode_w,
                          input logic [15:0] chan_w, input logic [1:0] n,
                          input logic [15:0] d0, input logic [15:0] d1,
                          input logic [15:0] d2, input logic [7:0] db, input logic rnd);
      pkt_row_t row;
      row.type_w  = type_w;
      row.mode_w  = mode_w;
      row.chan_w  = chan_w;
      row.n_data  = n;
      row.data[0] = d0;
      row.data[1] = d1;
      row.data[2] = d2;
      row.io_db   = db;
      row.rnd_db  = rnd;
      rows.push_back(row);
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Reference model
   ///////////////////////////////////////////////////////////////////////
   task automatic predict(input pkt_row_t row, input logic [7:0] db);
      cmd_pkg::io_state_t pay;
      cmd_pkg::io_state_t nxt;
      logic               bad;
      logic               go;
      logic               body;
      logic               do_set;
      logic               do_exe;
      logic               is_set;
      logic [15:0]        pf;
      logic [15:0]        code;
      bad = !word_ok(row.chan_w);
      for (int i = 0; i < int'(row.n_data); i++)
         bad |= !word_ok(row.data[i]);
      // Oldest data byte is the mask
      pay    = {word_byte(row.data[0]), word_byte(row.data[1]), word_byte(row.data[2])};
      nxt    = exp_st;
      go     = 1'b1;
      body   = 1'b1;
      do_set = 1'b0;
      do_exe = 1'b0;
      is_set = (row.mode_w == "01");
      pf     = "ER";
      code   = "00";
      if (row.type_w == "00") begin
         body = 1'b0;
         pf   = "OK";
         code = "01";
      end else if (row.type_w != "02") begin
         go = 1'b0;
      end else if (is_set || row.mode_w == "03") begin
         if (row.n_data != 2'd3) begin
            code = is_set ? 16'h3032 : 16'h3232;
         end else if (bad) begin
            code = is_set ? 16'h3033 : 16'h3233;
         end else begin
            pf     = "OK";
            code   = is_set ? 16'h3031 : 16'h3231;
            do_set = 1'b1;
            do_exe = !is_set;
         end
      end else if (row.mode_w == "02") begin
         if (row.n_data == 2'd0) begin
            pf     = "OK";
            code   = "11";
            do_exe = 1'b1;
         end else begin
            code = "12";
         end
      end else if (row.mode_w == "04") begin
         if (bad) begin
            code = "23";
         end else begin
            pf   = "OK";
            code = "21";
         end
      end
      // Masked bits hold, unmasked inputs take the pins
      if (do_set) begin
         nxt.mask = pay.mask;
         for (int b = 0; b < 8; b++) begin
            if (!pay.mask[b]) begin
               nxt.dir[b]  = pay.dir[b];
               nxt.data[b] = pay.dir[b] ? pay.data[b] : db[b];
            end
         end
         exp_st = nxt;
      end
      if (do_exe) begin
         exp_dir  = exp_st.dir;
         exp_dbo  = exp_st.data;
         exp_bank = word_byte(row.chan_w);
      end
      exp_words.delete();
      if (go) begin
         exp_words.push_back("ST");
         exp_words.push_back(row.type_w);
         exp_words.push_back(pf);
         exp_words.push_back(code);
         if (body) begin
            exp_words.push_back(row.chan_w);
            exp_words.push_back(byte_ascii(exp_st.mask));
            exp_words.push_back(byte_ascii(exp_st.dir));
            exp_words.push_back(byte_ascii(exp_st.data));
            exp_words.push_back({8'h0d, 8'h0a});
         end
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Stream driver and response wait
   ///////////////////////////////////////////////////////////////////////
   task automatic send_packet(input pkt_row_t row, input logic [7:0] db);
      logic [15:0] words[$];
      int          gap;
      words.push_back("ST");
      words.push_back(row.type_w);
      words.push_back(row.mode_w);
      words.push_back(row.chan_w);
      for (int i = 0; i < int'(row.n_data); i++)
         words.push_back(row.data[i]);
      words.push_back({8'h0d, 8'h0a});
      foreach (words[i]) begin
         @(posedge clk);
         #1;
         if (i == 0)
            i_io_db = db;
         i_rx.valid = 1'b1;
         i_rx.sop   = (i == 0);
         i_rx.eop   = (i == words.size() - 1);
         i_rx.word  = words[i];
         if (i != words.size() - 1) begin
            gap = $urandom_range(2, 0);
            repeat (gap) begin
               @(posedge clk);
               #1;
               i_rx = '0;
            end
         end
      end
      @(posedge clk);
      #1;
      i_rx = '0;
   endtask

   task automatic wait_valid(output bit seen, output int cycles);
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < resp_timeout) begin
         @(negedge clk);
         cycles++;
         seen = o_tx.valid;
      end
   endtask

   task automatic check_ports(input logic [7:0] dir, input logic [7:0] dbo,
                              input logic [7:0] bank);
      check_value("o_io_dir", o_io_dir, dir);
      check_value("o_io_db", o_io_db, dbo);
      check_value("o_io_bank", o_io_bank, bank);
   endtask

   task automatic build_table();
      add_row("00", "01", "00", 2'd0, 16'h0, 16'h0, 16'h0, 8'h00, 1'b0);
      add_row("02", "03", "3a", 2'd3, "F0", "5A", "C3", 8'h96, 1'b0);
      add_row("02", "03", "05", 2'd3, "0F", "FF", "a5", 8'h00, 1'b1);
      add_row("02", "01", "07", 2'd3, "30", "0C", "5c", 8'h00, 1'b1);
      add_row("02", "02", "07", 2'd0, 16'h0, 16'h0, 16'h0, 8'h00, 1'b1);
      add_row("02", "02", "07", 2'd1, "12", 16'h0, 16'h0, 8'h00, 1'b1);
      add_row("02", "01", "07", 2'd3, "00", "G1", "22", 8'h00, 1'b1);
      add_row("02", "03", "07", 2'd3, "zz", "00", "00", 8'h00, 1'b1);
      add_row("02", "01", "07", 2'd2, "11", "22", 16'h0, 8'h00, 1'b1);
      add_row("02", "03", "07", 2'd2, "11", "22", 16'h0, 8'h00, 1'b1);
      add_row("02", "04", "01", 2'd0, 16'h0, 16'h0, 16'h0, 8'h00, 1'b0);
      add_row("02", "04", "QQ", 2'd0, 16'h0, 16'h0, 16'h0, 8'h00, 1'b0);
      add_row("02", "09", "01", 2'd0, 16'h0, 16'h0, 16'h0, 8'h00, 1'b0);
      add_row("01", "01", "00", 2'd1, "AB", 16'h0, 16'h0, 8'h00, 1'b0);
      add_row("00", "01", "00", 2'd0, 16'h0, 16'h0, 16'h0, 8'h00, 1'b0);
      add_row("02", "03", "c1", 2'd3, "00", "FF", "3E", 8'h00, 1'b1);
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Main sequence
   ///////////////////////////////////////////////////////////////////////
   initial begin
      bit          seen;
      int          waited;
      int          prop_errs;
      logic [7:0]  db;
      logic [7:0]  old_dir;
      logic [7:0]  old_dbo;
      logic [7:0]  old_bank;
      pkt_row_t    row;
      i_arst_n = 1'b1;
      i_rx     = '0;
      i_io_db  = '0;
      n_checks = 0;
      n_errs   = 0;
      exp_st   = '0;
      exp_dir  = '0;
      exp_dbo  = '0;
      exp_bank = '0;
      void'($urandom(32'h80ed_865c));
      build_table();
      #1;
      i_arst_n = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      @(negedge clk);
      check_value("o_tx.valid", o_tx.valid, 1'b0);
      check_ports(8'h00, 8'h00, 8'h00);
      foreach (rows[r]) begin
         row      = rows[r];
         db       = row.rnd_db ? 8'($urandom) : row.io_db;
         old_dir  = exp_dir;
         old_dbo  = exp_dbo;
         old_bank = exp_bank;
         predict(row, db);
         send_packet(row, db);
         // Ports hold for one more edge, then move two edges after eop
         @(negedge clk);
         @(negedge clk);
         check_ports(old_dir, old_dbo, old_bank);
         @(negedge clk);
         check_ports(exp_dir, exp_dbo, exp_bank);
         if (exp_words.size() == 0) begin
            wait_valid(seen, waited);
            assert (!seen) else begin
               n_errs++;
               $display("Error: ignored command %0d still produced a response word", r);
            end
         end else begin
            foreach (exp_words[w]) begin
               wait_valid(seen, waited);
               assert (seen) else begin
                  n_errs++;
                  $display("Error: response word %0d of command %0d never arrived", w, r);
               end
               if (seen) begin
                  check_value("o_tx.valid delay", waited, 1);
                  check_value("o_tx.word", o_tx.word, exp_words[w]);
                  check_value("o_tx.eop", o_tx.eop, w == exp_words.size() - 1);
               end
            end
            @(negedge clk);
            check_value("o_tx.valid", o_tx.valid, 1'b0);
         end
      end
      prop_errs = i_pkt_decode_top.u_props.prop_errs;
      $display("Checks: %0d, check errors: %0d, property errors: %0d",
               n_checks, n_errs, prop_errs);
      if (n_errs == 0 && prop_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
